// File: rtl/alloc_pkg.sv
// workgroup allocator shared types
package alloc_pkg;

  // vgpr and lds spans, sizes carry one extra bit for a full bank
  localparam int VGPR_W = 8;
  localparam int LDS_W = 8;

  // free wavefront slots per cu
  localparam int WF_W = 4;

  // free workgroup slots per cu
  localparam int SLOT_W = 3;

  localparam int WG_ID_W = 8;

  // cu id field on the update and result structs, low bits used
  localparam int CU_FIELD_W = 8;

  typedef struct packed {
    logic [VGPR_W:0]   size;
    logic [VGPR_W-1:0] start;
  } vgpr_span_t;

  typedef struct packed {
    logic [LDS_W:0]   size;
    logic [LDS_W-1:0] start;
  } lds_span_t;

  // what one workgroup needs
  typedef struct packed {
    logic [WG_ID_W-1:0] wg_id;
    logic [WF_W-1:0]    num_wf;
    logic [VGPR_W:0]    vgpr_size;
    logic [LDS_W:0]     lds_size;
  } alloc_req_t;

  // one cu entry rewrite from the resource tracker
  typedef struct packed {
    logic [CU_FIELD_W-1:0] cu_id;
    vgpr_span_t            vgpr;
    lds_span_t             lds;
    logic [WF_W-1:0]       wf_count;
    logic [SLOT_W-1:0]     slot_count;
  } cu_update_t;

  typedef struct packed {
    logic [WG_ID_W-1:0]    wg_id;
    logic [CU_FIELD_W-1:0] cu_id;
    logic [VGPR_W-1:0]     vgpr_start;
    logic [LDS_W-1:0]      lds_start;
  } alloc_result_t;

endpackage

// File: rtl/res_table.sv
// per-cu resource entry table
`timescale 1ns/1ps

module res_table
  import alloc_pkg::*;
#(
  parameter type T_ENTRY = logic,
  parameter int  NUM_CU  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en_i,
  input  logic [CU_FIELD_W-1:0] wr_cu_i,
  input  T_ENTRY                wr_data_i,
  output T_ENTRY                entries_o [NUM_CU]
);

  T_ENTRY entry_q [NUM_CU];

  // addressed write, one entry per cu
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CU; i++) begin
        entry_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      for (int i = 0; i < NUM_CU; i++) begin
        if (wr_cu_i == CU_FIELD_W'(i)) begin
          entry_q[i] <= wr_data_i;
        end
      end
    end
  end

  // all entries visible at once for the fit compare
  always_comb begin
    for (int i = 0; i < NUM_CU; i++) begin
      entries_o[i] = entry_q[i];
    end
  end

  // the tracker only knows cu ids that exist
  a_wr_cu_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en_i |-> (wr_cu_i < NUM_CU)
  ) else $error("table write to cu %0d beyond NUM_CU", wr_cu_i);

endmodule

// File: rtl/alloc_decode.sv
// allocation request capture stage
`timescale 1ns/1ps

module alloc_decode
  import alloc_pkg::*;
#(
  parameter int NUM_CU = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  alloc_req_t        req_i,
  input  logic [NUM_CU-1:0] cu_busy_i,
  input  logic              hold_i,
  output logic              dec_valid_o,
  output alloc_req_t        dec_req_o,
  output logic [NUM_CU-1:0] dec_busy_o
);

  // stage valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid_o <= 1'b0;
    end else if (!hold_i) begin
      dec_valid_o <= start_i;
    end
  end

  // request and busy snapshot, frozen behind a held result
  always_ff @(posedge clk) begin
    if (!hold_i) begin
      dec_req_o  <= req_i;
      dec_busy_o <= cu_busy_i;
    end
  end

  // dispatcher must not start while a found result waits for ack
  a_no_start_in_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(start_i && hold_i)
  ) else $error("start_i raised while allocator holds a result");

endmodule

// File: rtl/fit_search.sv
// resource fit search stage
`timescale 1ns/1ps

module fit_search
  import alloc_pkg::*;
#(
  parameter int NUM_CU = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          hold_i,
  input  logic                          dec_valid_i,
  input  alloc_req_t                    dec_req_i,
  input  logic [NUM_CU-1:0]             dec_busy_i,
  input  logic                          upd_valid_i,
  input  cu_update_t                    upd_i,
  output logic                          fit_valid_o,
  output logic [NUM_CU-1:0]             fit_mask_o,
  output alloc_req_t                    fit_req_o,
  output logic [NUM_CU-1:0][VGPR_W-1:0] vgpr_start_o,
  output logic [NUM_CU-1:0][LDS_W-1:0]  lds_start_o
);

  vgpr_span_t        vgpr_tab [NUM_CU];
  lds_span_t         lds_tab  [NUM_CU];
  logic [WF_W-1:0]   wf_tab   [NUM_CU];
  logic [SLOT_W-1:0] slot_tab [NUM_CU];

  logic [NUM_CU-1:0] cu_init_q;
  logic [NUM_CU-1:0] fit_d;

  res_table #(.T_ENTRY(vgpr_span_t), .NUM_CU(NUM_CU)) u_vgpr_tab (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (upd_valid_i),
    .wr_cu_i   (upd_i.cu_id),
    .wr_data_i (upd_i.vgpr),
    .entries_o (vgpr_tab)
  );

  res_table #(.T_ENTRY(lds_span_t), .NUM_CU(NUM_CU)) u_lds_tab (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (upd_valid_i),
    .wr_cu_i   (upd_i.cu_id),
    .wr_data_i (upd_i.lds),
    .entries_o (lds_tab)
  );

  res_table #(.T_ENTRY(logic [WF_W-1:0]), .NUM_CU(NUM_CU)) u_wf_tab (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (upd_valid_i),
    .wr_cu_i   (upd_i.cu_id),
    .wr_data_i (upd_i.wf_count),
    .entries_o (wf_tab)
  );

  res_table #(.T_ENTRY(logic [SLOT_W-1:0]), .NUM_CU(NUM_CU)) u_slot_tab (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (upd_valid_i),
    .wr_cu_i   (upd_i.cu_id),
    .wr_data_i (upd_i.slot_count),
    .entries_o (slot_tab)
  );

  // cu seen at least once by the update port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cu_init_q <= '0;
    end else if (upd_valid_i) begin
      for (int i = 0; i < NUM_CU; i++) begin
        if (upd_i.cu_id == CU_FIELD_W'(i)) begin
          cu_init_q[i] <= 1'b1;
        end
      end
    end
  end

  // all four resources must fit, and one free wg slot
  always_comb begin
    for (int i = 0; i < NUM_CU; i++) begin
      fit_d[i] = (vgpr_tab[i].size >= dec_req_i.vgpr_size) &&
                 (lds_tab[i].size >= dec_req_i.lds_size) &&
                 (wf_tab[i] >= dec_req_i.num_wf) &&
                 (slot_tab[i] != '0) &&
                 !dec_busy_i[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fit_valid_o <= 1'b0;
    end else if (!hold_i) begin
      fit_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_i) begin
      fit_mask_o <= fit_d;
      fit_req_o  <= dec_req_i;
      for (int i = 0; i < NUM_CU; i++) begin
        vgpr_start_o[i] <= cu_init_q[i] ? vgpr_tab[i].start : '0;
        lds_start_o[i]  <= cu_init_q[i] ? lds_tab[i].start : '0;
      end
    end
  end

endmodule

// File: rtl/cu_select.sv
// preferred round-robin cu pick and result stage
`timescale 1ns/1ps

module cu_select
  import alloc_pkg::*;
#(
  parameter int NUM_CU = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ack_i,
  input  logic                          fit_valid_i,
  input  logic [NUM_CU-1:0]             fit_mask_i,
  input  alloc_req_t                    fit_req_i,
  input  logic [NUM_CU-1:0][VGPR_W-1:0] vgpr_start_i,
  input  logic [NUM_CU-1:0][LDS_W-1:0]  lds_start_i,
  output logic                          hold_o,
  output logic                          valid_o,
  output logic                          rejected_o,
  output alloc_result_t                 result_o
);

  localparam int CU_ID_W = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;

  logic [CU_ID_W-1:0] pref_idx;
  logic [CU_ID_W-1:0] pick;
  logic               found;
  alloc_result_t      result_d;

  // spread workgroups over cus by id
  assign pref_idx = CU_ID_W'(fit_req_i.wg_id % NUM_CU);

  // first fitting cu at or above the preferred one, wrapping to zero
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    pick  = '0;
    for (int i = 0; i < NUM_CU; i++) begin
      idx = (int'(pref_idx) + i) % NUM_CU;
      if (!found && fit_mask_i[idx]) begin
        found = 1'b1;
        pick  = CU_ID_W'(idx);
      end
    end
  end

  always_comb begin
    result_d.wg_id      = fit_req_i.wg_id;
    result_d.cu_id      = CU_FIELD_W'(pick);
    result_d.vgpr_start = vgpr_start_i[pick];
    result_d.lds_start  = lds_start_i[pick];
  end

  // a found result waits for ack, a rejection shows for one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold_o     <= 1'b0;
      valid_o    <= 1'b0;
      rejected_o <= 1'b0;
    end else if (hold_o) begin
      if (ack_i) begin
        hold_o  <= 1'b0;
        valid_o <= 1'b0;
      end
    end else begin
      hold_o     <= fit_valid_i & found;
      valid_o    <= fit_valid_i;
      rejected_o <= fit_valid_i & ~found;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_o) begin
      result_o <= result_d;
    end
  end

  // ack only answers a presented found result
  a_ack_in_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    ack_i |-> hold_o
  ) else $error("ack_i without a held result");

endmodule

// File: rtl/wg_allocator.sv
// workgroup allocator top
`timescale 1ns/1ps

module wg_allocator
  import alloc_pkg::*;
#(
  parameter int NUM_CU = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  alloc_req_t        req_i,
  input  logic [NUM_CU-1:0] cu_busy_i,
  input  logic              upd_valid_i,
  input  cu_update_t        upd_i,
  input  logic              ack_i,
  output logic              valid_o,
  output logic              rejected_o,
  output alloc_result_t     result_o
);

  logic                          hold;
  logic                          dec_valid;
  alloc_req_t                    dec_req;
  logic [NUM_CU-1:0]             dec_busy;
  logic                          fit_valid;
  logic [NUM_CU-1:0]             fit_mask;
  alloc_req_t                    fit_req;
  logic [NUM_CU-1:0][VGPR_W-1:0] vgpr_start;
  logic [NUM_CU-1:0][LDS_W-1:0]  lds_start;

  alloc_decode #(.NUM_CU(NUM_CU)) u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .req_i       (req_i),
    .cu_busy_i   (cu_busy_i),
    .hold_i      (hold),
    .dec_valid_o (dec_valid),
    .dec_req_o   (dec_req),
    .dec_busy_o  (dec_busy)
  );

  fit_search #(.NUM_CU(NUM_CU)) u_search (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold_i       (hold),
    .dec_valid_i  (dec_valid),
    .dec_req_i    (dec_req),
    .dec_busy_i   (dec_busy),
    .upd_valid_i  (upd_valid_i),
    .upd_i        (upd_i),
    .fit_valid_o  (fit_valid),
    .fit_mask_o   (fit_mask),
    .fit_req_o    (fit_req),
    .vgpr_start_o (vgpr_start),
    .lds_start_o  (lds_start)
  );

  cu_select #(.NUM_CU(NUM_CU)) u_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .ack_i        (ack_i),
    .fit_valid_i  (fit_valid),
    .fit_mask_i   (fit_mask),
    .fit_req_i    (fit_req),
    .vgpr_start_i (vgpr_start),
    .lds_start_i  (lds_start),
    .hold_o       (hold),
    .valid_o      (valid_o),
    .rejected_o   (rejected_o),
    .result_o     (result_o)
  );

endmodule

// File: verification/tb_wg_allocator.sv
// workgroup allocator testbench
`timescale 1ns/1ps

module tb_wg_allocator
  import alloc_pkg::*;
();

  localparam int NUM_CU  = 4;
  localparam int TIMEOUT = 50;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              start_i;
  alloc_req_t        req_i;
  logic [NUM_CU-1:0] cu_busy_i;
  logic              upd_valid_i;
  cu_update_t        upd_i;
  logic              ack_i;
  logic              valid_o;
  logic              rejected_o;
  alloc_result_t     result_o;

  int seed   = 32'h0410d022;
  int errors = 0;
  int tests  = 0;

  // reference copy of the cu table
  cu_update_t        model [NUM_CU];
  logic [NUM_CU-1:0] model_init;

  always #10 clk = ~clk;

  wg_allocator #(.NUM_CU(NUM_CU)) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .req_i       (req_i),
    .cu_busy_i   (cu_busy_i),
    .upd_valid_i (upd_valid_i),
    .upd_i       (upd_i),
    .ack_i       (ack_i),
    .valid_o     (valid_o),
    .rejected_o  (rejected_o),
    .result_o    (result_o)
  );

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic finish_test(string name, int errs_before);
    tests++;
    if (errors == errs_before)
      $display("test %s passed", name);
    else
      $display("test %s failed with %0d errors", name, errors - errs_before);
  endtask

  // all tasks start and end on a falling edge
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    model_init = '0;
    for (int i = 0; i < NUM_CU; i++) begin
      model[i] = '0;
    end
  endtask

  task automatic write_entry(int cu, logic [VGPR_W:0] vsize, logic [VGPR_W-1:0] vstart,
                             logic [LDS_W:0] lsize, logic [LDS_W-1:0] lstart,
                             logic [WF_W-1:0] wf, logic [SLOT_W-1:0] slot);
    cu_update_t u;
    u.cu_id      = CU_FIELD_W'(cu);
    u.vgpr.size  = vsize;
    u.vgpr.start = vstart;
    u.lds.size   = lsize;
    u.lds.start  = lstart;
    u.wf_count   = wf;
    u.slot_count = slot;
    upd_valid_i  = 1'b1;
    upd_i        = u;
    model[cu]      = u;
    model_init[cu] = 1'b1;
    @(negedge clk);
    upd_valid_i = 1'b0;
  endtask

  task automatic send_request(alloc_req_t req, logic [NUM_CU-1:0] busy);
    start_i   = 1'b1;
    req_i     = req;
    cu_busy_i = busy;
    @(negedge clk);
    start_i   = 1'b0;
    cu_busy_i = '0;
  endtask

  // first fitting cu from wg_id mod NUM_CU upward, wrapping
  task automatic expect_alloc(input alloc_req_t req, input logic [NUM_CU-1:0] busy,
                              output logic found, output alloc_result_t res);
    int   pref;
    int   cu;
    logic fits;
    found     = 1'b0;
    res       = '0;
    res.wg_id = req.wg_id;
    pref      = int'(req.wg_id) % NUM_CU;
    for (int k = 0; k < NUM_CU; k++) begin
      cu   = (pref + k) % NUM_CU;
      fits = (model[cu].vgpr.size >= req.vgpr_size) && (model[cu].lds.size >= req.lds_size) &&
             (model[cu].wf_count >= req.num_wf) && (model[cu].slot_count != '0) && !busy[cu];
      if (!found && fits) begin
        found          = 1'b1;
        res.cu_id      = CU_FIELD_W'(cu);
        res.vgpr_start = model_init[cu] ? model[cu].vgpr.start : '0;
        res.lds_start  = model_init[cu] ? model[cu].lds.start : '0;
      end
    end
  endtask

  task automatic wait_valid(output bit ok);
    int n;
    n = 0;
    while (valid_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = (valid_o === 1'b1);
    if (!ok) begin
      $display("no result came out within %0d cycles", TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_result(logic exp_found, alloc_result_t exp);
    if (rejected_o !== !exp_found)
      report_mismatch("rejected_o", rejected_o, !exp_found);
    if (exp_found) begin
      if (result_o.wg_id !== exp.wg_id)
        report_mismatch("result_o.wg_id", result_o.wg_id, exp.wg_id);
      if (result_o.cu_id !== exp.cu_id)
        report_mismatch("result_o.cu_id", result_o.cu_id, exp.cu_id);
      if (result_o.vgpr_start !== exp.vgpr_start)
        report_mismatch("result_o.vgpr_start", result_o.vgpr_start, exp.vgpr_start);
      if (result_o.lds_start !== exp.lds_start)
        report_mismatch("result_o.lds_start", result_o.lds_start, exp.lds_start);
    end
  endtask

  task automatic ack_result();
    ack_i = 1'b1;
    @(negedge clk);
    ack_i = 1'b0;
    if (valid_o !== 1'b0)
      report_mismatch("valid_o", valid_o, 0);
  endtask

  task automatic run_request(alloc_req_t req, logic [NUM_CU-1:0] busy);
    logic          exp_found;
    alloc_result_t exp;
    bit            ok;
    expect_alloc(req, busy, exp_found, exp);
    send_request(req, busy);
    wait_valid(ok);
    if (ok) begin
      check_result(exp_found, exp);
      if (!rejected_o) begin
        ack_result();
      end else begin
        // a rejection shows for one cycle only
        @(negedge clk);
        if (valid_o !== 1'b0)
          report_mismatch("valid_o", valid_o, 0);
      end
    end
  endtask

  task automatic test_reject_empty();
    alloc_req_t req;
    int         e0;
    e0            = errors;
    req           = '0;
    req.wg_id     = 8'h05;
    req.num_wf    = 4'd1;
    req.vgpr_size = (VGPR_W+1)'(rand_range(1, 256));
    run_request(req, '0);
    finish_test("reject_empty", e0);
  endtask

  task automatic test_single_fit();
    alloc_req_t req;
    int         e0;
    e0 = errors;
    write_entry(2, 9'd128, 8'h40, 9'd96, 8'h20, 4'd8, 3'd2);
    req.wg_id     = WG_ID_W'(rand_range(0, 255));
    req.num_wf    = WF_W'(rand_range(1, 8));
    req.vgpr_size = (VGPR_W+1)'(rand_range(1, 128));
    req.lds_size  = (LDS_W+1)'(rand_range(1, 96));
    run_request(req, '0);
    finish_test("single_fit", e0);
  endtask

  task automatic test_round_robin();
    alloc_req_t req;
    int         e0;
    e0 = errors;
    for (int cu = 0; cu < NUM_CU; cu++) begin
      write_entry(cu, 9'd200, 8'(8'h10 * cu + 8'h08), 9'd200, 8'(8'h30 + 8 * cu), 4'd8, 3'd4);
    end
    req.wg_id     = WG_ID_W'(1 + NUM_CU * rand_range(0, 60));
    req.num_wf    = WF_W'(rand_range(1, 8));
    req.vgpr_size = (VGPR_W+1)'(rand_range(1, 100));
    req.lds_size  = (LDS_W+1)'(rand_range(1, 100));
    run_request(req, '0);
    run_request(req, 4'b0010);
    // cu 1 short on vgpr only
    write_entry(1, req.vgpr_size - 1'b1, 8'h18, 9'd200, 8'h38, 4'd8, 3'd4);
    run_request(req, '0);
    finish_test("round_robin", e0);
  endtask

  task automatic test_back_pressure();
    alloc_req_t    req_a;
    alloc_req_t    req_b;
    logic          found_a;
    logic          found_b;
    alloc_result_t exp_a;
    alloc_result_t exp_b;
    alloc_result_t held;
    bit            ok;
    int            e0;
    e0 = errors;
    req_a.wg_id     = WG_ID_W'(rand_range(0, 127));
    req_a.num_wf    = WF_W'(rand_range(1, 4));
    req_a.vgpr_size = (VGPR_W+1)'(rand_range(1, 50));
    req_a.lds_size  = (LDS_W+1)'(rand_range(1, 50));
    req_b           = req_a;
    req_b.wg_id     = req_a.wg_id + 8'd3;
    expect_alloc(req_a, '0, found_a, exp_a);
    expect_alloc(req_b, '0, found_b, exp_b);
    send_request(req_a, '0);
    send_request(req_b, '0);
    wait_valid(ok);
    if (ok) begin
      check_result(found_a, exp_a);
      held = result_o;
      repeat (10) begin
        @(negedge clk);
        if (valid_o !== 1'b1)
          report_mismatch("valid_o", valid_o, 1);
        if (result_o !== held)
          report_mismatch("result_o", result_o, held);
      end
      ack_result();
      wait_valid(ok);
      if (ok) begin
        check_result(found_b, exp_b);
        if (!rejected_o)
          ack_result();
      end
    end
    finish_test("back_pressure", e0);
  endtask

  task automatic test_zero_start();
    alloc_req_t req;
    int         e0;
    e0 = errors;
    apply_reset();
    req       = '0;
    req.wg_id = 8'h0a;
    run_request(req, '0);
    write_entry(3, 9'd0, 8'h00, 9'd0, 8'h00, 4'd0, 3'd1);
    run_request(req, '0);
    finish_test("zero_start", e0);
  endtask

  initial begin
    rst_n       = 1'b0;
    start_i     = 1'b0;
    req_i       = '0;
    cu_busy_i   = '0;
    upd_valid_i = 1'b0;
    upd_i       = '0;
    ack_i       = 1'b0;
    apply_reset();
    test_reject_empty();
    test_single_fit();
    test_round_robin();
    test_back_pressure();
    test_zero_start();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: build.f
rtl/alloc_pkg.sv
rtl/res_table.sv
rtl/alloc_decode.sv
rtl/fit_search.sv
rtl/cu_select.sv
rtl/wg_allocator.sv
verification/tb_wg_allocator.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_wg_allocator
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
